// ==== common/accel_cfg.svh ====
`ifndef ACCEL_CFG_SVH
`define ACCEL_CFG_SVH

// host I/O port, word addressed through bits [5:2]
`define ACCEL_IO_ADDR_WIDTH 12

// I/O and packet memory word width
`define ACCEL_DATA_WIDTH 32

// packet memory word address
`define ACCEL_PMEM_ADDR_WIDTH 10

// scan length in words
`define ACCEL_LEN_WIDTH 12

// rule id stored in each rule table entry
`define ACCEL_RULE_ID_WIDTH 7

// FIFO depth is 2**ACCEL_FIFO_ADDR_WIDTH
`define ACCEL_FIFO_ADDR_WIDTH 2

`endif

// ==== common/accel_reg_pkg.sv ====
package accel_reg_pkg;

  // word offsets inside the accelerator page, compared against {io_addr[5:2], 2'b00}
  typedef enum logic [5:0] {
    CTRL    = 6'h00,
    LEN     = 6'h04,
    ADDR    = 6'h08,
    LANES   = 6'h0c,
    RULE    = 6'h20,
    RELEASE = 6'h28,
    SLOT    = 6'h30
  } reg_offset_e;

  // offsets on the aggregate status page
  typedef enum logic [5:0] {
    STAT_ANY      = 6'h00,
    STAT_DONE     = 6'h04,
    STAT_MATCH    = 6'h08,
    STAT_BUSY     = 6'h0c,
    STAT_DONE_ERR = 6'h14
  } stat_offset_e;

  // io_addr bit that selects the aggregate page
  localparam int STATUS_REGION_BIT = 10;

  // CTRL write bits
  localparam int CTRL_START_BIT = 0;
  localparam int CTRL_STOP_BIT  = 4;

  // CTRL read bits
  localparam int STAT_BUSY_BIT         = 1;
  localparam int STAT_DONE_BIT         = 8;
  localparam int STAT_MATCH_BIT        = 9;
  localparam int STAT_RESULT_VALID_BIT = 16;

  // SLOT read, result valid sits above the slot byte
  localparam int SLOT_VALID_BIT = 8;

endpackage

// ==== common/accel_scan_pkg.sv ====
`include "accel_cfg.svh"

package accel_scan_pkg;

  typedef logic [`ACCEL_PMEM_ADDR_WIDTH-1:0] pmem_addr_t;
  typedef logic [`ACCEL_LEN_WIDTH-1:0]       scan_len_t;
  typedef logic [`ACCEL_RULE_ID_WIDTH-1:0]   rule_id_t;
  typedef logic [7:0]                        slot_t;

  // one bit per byte lane of a packet word
  typedef logic [`ACCEL_DATA_WIDTH/8-1:0]    lane_mask_t;

  // rule table entry, indexed by byte value
  typedef struct packed {
    logic     valid;
    rule_id_t id;
  } rule_entry_t;

  // record queued at the end of every scan
  typedef struct packed {
    slot_t    slot;
    rule_id_t rule;
    logic     hit;
  } scan_result_t;

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    FLUSH,
    REPORT
  } scan_state_e;

endpackage

// ==== design/sync_fifo.sv ====
`include "accel_cfg.svh"

module sync_fifo #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t din,
  input  logic     pop,
  output payload_t dout,
  output logic     valid,
  output logic     full
);

  localparam int AW    = `ACCEL_FIFO_ADDR_WIDTH;
  localparam int DEPTH = 1 << AW;

  payload_t    mem [DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        do_push;
  logic        do_pop;

  // extra pointer bit tells full from empty
  assign valid = (wr_ptr != rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  assign do_push = push && !full;
  assign do_pop  = pop && valid;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr[AW-1:0]] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // head word is visible without a pop
  assign dout = mem[rd_ptr[AW-1:0]];

endmodule

// ==== design/accel_regs.sv ====
`include "accel_cfg.svh"

module accel_regs (
  input  logic                               clk,
  input  logic                               rst,

  input  logic                               io_en,
  input  logic                               io_wen,
  input  logic [`ACCEL_DATA_WIDTH/8-1:0]     io_strb,
  input  logic [`ACCEL_IO_ADDR_WIDTH-1:0]    io_addr,
  input  logic [`ACCEL_DATA_WIDTH-1:0]       io_wr_data,
  output logic [`ACCEL_DATA_WIDTH-1:0]       io_rd_data,
  output logic                               io_rd_valid,

  output logic                               start,
  output logic                               stop,
  output logic                               release_pulse,
  output accel_scan_pkg::pmem_addr_t         desc_addr,
  output accel_scan_pkg::scan_len_t          desc_len,
  output accel_scan_pkg::slot_t              desc_slot,

  input  logic                               busy,
  input  logic                               scan_done,
  input  logic                               start_rejected,
  input  logic                               hit_any,
  input  accel_scan_pkg::lane_mask_t         lane_mask,
  input  accel_scan_pkg::rule_id_t           first_rule,
  input  logic                               result_valid,
  input  accel_scan_pkg::scan_result_t       result_head
);

  logic [5:0]                   offset;
  logic                         status_page;
  logic                         wr_req;
  logic                         rd_req;
  logic                         ctrl_wr;
  logic                         start_accepted;
  logic                         done;
  logic                         match;
  logic                         done_err;
  logic                         lanes_ready;
  logic                         lanes_read;
  logic                         lanes_stall;
  logic [`ACCEL_DATA_WIDTH-1:0] rd_word;

  assign offset      = {io_addr[5:2], 2'b00};
  assign status_page = io_addr[accel_reg_pkg::STATUS_REGION_BIT];
  assign wr_req      = io_en && io_wen && !status_page;
  assign rd_req      = io_en && !io_wen;
  assign ctrl_wr     = wr_req && (offset == accel_reg_pkg::CTRL) && io_strb[0];

  assign start_accepted = start && !start_rejected;

  // flags that clear this cycle must not end a LANES stall
  assign lanes_ready = (done || match) && !start_accepted;
  assign lanes_read  = lanes_stall ||
                       (rd_req && !status_page && (offset == accel_reg_pkg::LANES));

  // control pulses land one cycle after the write
  always_ff @(posedge clk) begin
    if (rst) begin
      start         <= 1'b0;
      stop          <= 1'b0;
      release_pulse <= 1'b0;
    end else begin
      start         <= ctrl_wr && io_wr_data[accel_reg_pkg::CTRL_START_BIT];
      stop          <= ctrl_wr && io_wr_data[accel_reg_pkg::CTRL_STOP_BIT];
      release_pulse <= wr_req && (offset == accel_reg_pkg::RELEASE);
    end
  end

  // scan descriptor
  always_ff @(posedge clk) begin
    if (wr_req) begin
      case (offset)
        accel_reg_pkg::LEN:  desc_len  <= io_wr_data[`ACCEL_LEN_WIDTH-1:0];
        accel_reg_pkg::ADDR: desc_addr <= io_wr_data[`ACCEL_PMEM_ADDR_WIDTH-1:0];
        accel_reg_pkg::SLOT: desc_slot <= io_wr_data[7:0];
        default: ;
      endcase
    end
  end

  // sticky status, cleared by an accepted start
  always_ff @(posedge clk) begin
    if (rst) begin
      done     <= 1'b0;
      match    <= 1'b0;
      done_err <= 1'b0;
    end else if (start_accepted) begin
      done     <= 1'b0;
      match    <= 1'b0;
      done_err <= 1'b0;
    end else begin
      done     <= done || scan_done || stop;
      match    <= match || hit_any;
      done_err <= done_err || start_rejected;
    end
  end

  always_comb begin
    rd_word = '0;
    if (status_page) begin
      case (offset)
        accel_reg_pkg::STAT_ANY:      rd_word[0] = done || match;
        accel_reg_pkg::STAT_DONE:     rd_word[0] = done;
        accel_reg_pkg::STAT_MATCH:    rd_word[0] = match;
        accel_reg_pkg::STAT_BUSY:     rd_word[0] = busy;
        accel_reg_pkg::STAT_DONE_ERR: rd_word[0] = done_err;
        default: ;
      endcase
    end else begin
      case (offset)
        accel_reg_pkg::CTRL: begin
          rd_word[accel_reg_pkg::STAT_BUSY_BIT]         = busy;
          rd_word[accel_reg_pkg::STAT_DONE_BIT]         = done;
          rd_word[accel_reg_pkg::STAT_MATCH_BIT]        = match;
          rd_word[accel_reg_pkg::STAT_RESULT_VALID_BIT] = result_valid;
        end
        accel_reg_pkg::LEN:   rd_word[`ACCEL_LEN_WIDTH-1:0]       = desc_len;
        accel_reg_pkg::ADDR:  rd_word[`ACCEL_PMEM_ADDR_WIDTH-1:0] = desc_addr;
        accel_reg_pkg::LANES: rd_word[$bits(lane_mask)-1:0]       = lane_mask;
        accel_reg_pkg::RULE:  rd_word[`ACCEL_RULE_ID_WIDTH-1:0]   = first_rule;
        accel_reg_pkg::SLOT: begin
          // head record when one is queued, else the descriptor slot
          rd_word[accel_reg_pkg::SLOT_VALID_BIT] = result_valid;
          rd_word[7:0] = result_valid ? result_head.slot : desc_slot;
        end
        default: ;
      endcase
    end
  end

  // read-back, LANES holds valid low until done or match
  always_ff @(posedge clk) begin
    if (rst) begin
      io_rd_valid <= 1'b0;
      lanes_stall <= 1'b0;
    end else if (lanes_read) begin
      io_rd_valid <= lanes_ready;
      lanes_stall <= !lanes_ready;
    end else begin
      io_rd_valid <= rd_req;
    end
  end

  // the core holds io_addr while stalled, so the mask stays current
  always_ff @(posedge clk) begin
    if (rd_req || lanes_stall) begin
      io_rd_data <= rd_word;
    end
  end

endmodule

// ==== scan/scan_ctrl_fsm.sv ====
module scan_ctrl_fsm (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic stop,
  input  logic counter_last,
  input  logic counter_zero,
  input  logic result_full,
  output logic busy,
  output logic counter_load,
  output logic counter_step,
  output logic mem_rd_en,
  output logic scan_done,
  output logic start_rejected,
  output logic match_clear
);

  accel_scan_pkg::scan_state_e state;
  accel_scan_pkg::scan_state_e state_next;
  logic                        idle;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= accel_scan_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      accel_scan_pkg::IDLE: begin
        if (start) state_next = accel_scan_pkg::FETCH;
      end
      accel_scan_pkg::FETCH: begin
        // empty scans skip the flush, nothing is in flight
        if (counter_zero) begin
          state_next = accel_scan_pkg::REPORT;
        end else if (stop || counter_last) begin
          state_next = accel_scan_pkg::FLUSH;
        end
      end
      // one cycle for the last read data to reach the matcher
      accel_scan_pkg::FLUSH: state_next = accel_scan_pkg::REPORT;
      accel_scan_pkg::REPORT: begin
        if (!result_full) state_next = accel_scan_pkg::IDLE;
      end
      default: state_next = accel_scan_pkg::IDLE;
    endcase
  end

  assign idle           = (state == accel_scan_pkg::IDLE);
  assign busy           = !idle;
  assign counter_load   = start && idle;
  assign match_clear    = start && idle;
  assign start_rejected = start && !idle;

  // one read per cycle, a stop suppresses the read in its own cycle
  assign mem_rd_en    = (state == accel_scan_pkg::FETCH) && !counter_zero && !stop;
  assign counter_step = mem_rd_en;

  // holds in REPORT while the result queue is full
  assign scan_done = (state == accel_scan_pkg::REPORT) && !result_full;

endmodule

// ==== scan/scan_word_counter.sv ====
module scan_word_counter (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       load,
  input  logic                       step,
  input  accel_scan_pkg::pmem_addr_t load_addr,
  input  accel_scan_pkg::scan_len_t  load_len,
  output accel_scan_pkg::pmem_addr_t addr,
  output logic                       last,
  output logic                       zero
);

  // words still to be read
  accel_scan_pkg::scan_len_t remaining;

  always_ff @(posedge clk) begin
    if (rst) begin
      addr      <= '0;
      remaining <= '0;
    end else if (load) begin
      addr      <= load_addr;
      remaining <= load_len;
    end else if (step) begin
      // address wraps at the end of packet memory
      addr      <= addr + 1'b1;
      remaining <= remaining - 1'b1;
    end
  end

  assign last = (remaining == accel_scan_pkg::scan_len_t'(1));
  assign zero = (remaining == '0);

endmodule

// ==== scan/scan_byte_matcher.sv ====
`include "accel_cfg.svh"

module scan_byte_matcher (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          clear,
  input  logic                          word_valid,
  input  logic [`ACCEL_DATA_WIDTH-1:0]  word,
  input  logic                          rule_wr_en,
  input  logic [7:0]                    rule_wr_addr,
  input  accel_scan_pkg::rule_entry_t   rule_wr_data,
  output logic                          hit_any,
  output accel_scan_pkg::lane_mask_t    lane_mask,
  output accel_scan_pkg::rule_id_t      first_rule
);

  localparam int LANE_COUNT = `ACCEL_DATA_WIDTH / 8;

  accel_scan_pkg::rule_entry_t rule_table [256];
  accel_scan_pkg::rule_entry_t lane_entry [LANE_COUNT];
  accel_scan_pkg::lane_mask_t  lane_hit;
  accel_scan_pkg::rule_id_t    lane_first_id;
  logic                        word_valid_q;

  always_ff @(posedge clk) begin
    if (rule_wr_en) begin
      rule_table[rule_wr_addr] <= rule_wr_data;
    end
  end

  // memory data arrives one cycle after the read enable
  always_ff @(posedge clk) begin
    if (rst) begin
      word_valid_q <= 1'b0;
    end else begin
      word_valid_q <= word_valid;
    end
  end

  always_comb begin
    for (int i = 0; i < LANE_COUNT; i++) begin
      lane_entry[i] = rule_table[word[8*i +: 8]];
      lane_hit[i]   = word_valid_q && lane_entry[i].valid;
    end
  end

  // lowest hit lane wins
  always_comb begin
    lane_first_id = '0;
    for (int i = LANE_COUNT - 1; i >= 0; i--) begin
      if (lane_hit[i]) lane_first_id = lane_entry[i].id;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      hit_any    <= 1'b0;
      lane_mask  <= '0;
      first_rule <= '0;
    end else if (|lane_hit) begin
      hit_any   <= 1'b1;
      lane_mask <= lane_mask | lane_hit;
      // keep the id from the earliest hitting word
      if (!hit_any) first_rule <= lane_first_id;
    end
  end

endmodule

// ==== design/accel_wrap.sv ====
`include "accel_cfg.svh"

module accel_wrap (
  input  logic                              clk,
  input  logic                              rst,

  input  logic                              io_en,
  input  logic                              io_wen,
  input  logic [`ACCEL_DATA_WIDTH/8-1:0]    io_strb,
  input  logic [`ACCEL_IO_ADDR_WIDTH-1:0]   io_addr,
  input  logic [`ACCEL_DATA_WIDTH-1:0]      io_wr_data,
  output logic [`ACCEL_DATA_WIDTH-1:0]      io_rd_data,
  output logic                              io_rd_valid,

  input  logic                              rule_wr_en,
  input  logic [7:0]                        rule_wr_addr,
  input  accel_scan_pkg::rule_entry_t       rule_wr_data,

  output logic                              mem_rd_en,
  output accel_scan_pkg::pmem_addr_t        mem_rd_addr,
  input  logic [`ACCEL_DATA_WIDTH-1:0]      mem_rd_data
);

  logic                          start;
  logic                          stop;
  logic                          release_pulse;
  accel_scan_pkg::pmem_addr_t    desc_addr;
  accel_scan_pkg::scan_len_t     desc_len;
  accel_scan_pkg::slot_t         desc_slot;
  logic                          busy;
  logic                          scan_done;
  logic                          start_rejected;
  logic                          counter_load;
  logic                          counter_step;
  logic                          counter_last;
  logic                          counter_zero;
  logic                          match_clear;
  logic                          hit_any;
  accel_scan_pkg::lane_mask_t    lane_mask;
  accel_scan_pkg::rule_id_t      first_rule;
  accel_scan_pkg::slot_t         slot_head;
  accel_scan_pkg::scan_result_t  result_in;
  accel_scan_pkg::scan_result_t  result_head;
  logic                          result_valid;
  logic                          result_full;

  accel_regs regs_i (
    .clk(clk), .rst(rst),
    .io_en(io_en), .io_wen(io_wen), .io_strb(io_strb), .io_addr(io_addr),
    .io_wr_data(io_wr_data), .io_rd_data(io_rd_data), .io_rd_valid(io_rd_valid),
    .start(start), .stop(stop), .release_pulse(release_pulse),
    .desc_addr(desc_addr), .desc_len(desc_len), .desc_slot(desc_slot),
    .busy(busy), .scan_done(scan_done), .start_rejected(start_rejected),
    .hit_any(hit_any), .lane_mask(lane_mask), .first_rule(first_rule),
    .result_valid(result_valid), .result_head(result_head)
  );

  scan_ctrl_fsm fsm_i (
    .clk(clk), .rst(rst), .start(start), .stop(stop),
    .counter_last(counter_last), .counter_zero(counter_zero), .result_full(result_full),
    .busy(busy), .counter_load(counter_load), .counter_step(counter_step),
    .mem_rd_en(mem_rd_en), .scan_done(scan_done), .start_rejected(start_rejected),
    .match_clear(match_clear)
  );

  scan_word_counter counter_i (
    .clk(clk), .rst(rst), .load(counter_load), .step(counter_step),
    .load_addr(desc_addr), .load_len(desc_len),
    .addr(mem_rd_addr), .last(counter_last), .zero(counter_zero)
  );

  // the matcher delays mem_rd_en to line up with mem_rd_data
  scan_byte_matcher matcher_i (
    .clk(clk), .rst(rst), .clear(match_clear),
    .word_valid(mem_rd_en), .word(mem_rd_data),
    .rule_wr_en(rule_wr_en), .rule_wr_addr(rule_wr_addr), .rule_wr_data(rule_wr_data),
    .hit_any(hit_any), .lane_mask(lane_mask), .first_rule(first_rule)
  );

  // slot of the running scan
  sync_fifo #(.payload_t(accel_scan_pkg::slot_t)) slot_fifo (
    .clk(clk), .rst(rst), .push(counter_load), .din(desc_slot), .pop(scan_done),
    .dout(slot_head), .valid(), .full()
  );

  assign result_in = '{slot: slot_head, rule: first_rule, hit: hit_any};

  sync_fifo #(.payload_t(accel_scan_pkg::scan_result_t)) result_fifo (
    .clk(clk), .rst(rst), .push(scan_done), .din(result_in), .pop(release_pulse),
    .dout(result_head), .valid(result_valid), .full(result_full)
  );

endmodule

// ==== sim/accel_wrap_checker.sv ====
`include "accel_cfg.svh"

module accel_wrap_checker (
  input logic                            clk,
  input logic                            rst,
  input logic                            io_en,
  input logic                            io_wen,
  input logic [`ACCEL_IO_ADDR_WIDTH-1:0] io_addr,
  input logic                            io_rd_valid,
  input logic                            mem_rd_en,
  input logic                            busy
);

  timeunit 1ns;
  timeprecision 1ps;

  logic plain_read;

  // every read except the stalling LANES read
  assign plain_read = io_en && !io_wen &&
                      (io_addr[accel_reg_pkg::STATUS_REGION_BIT] ||
                       ({io_addr[5:2], 2'b00} != accel_reg_pkg::LANES));

  no_read_when_idle: assert property (@(posedge clk) disable iff (rst)
    !(mem_rd_en && !busy))
    else $error("memory read issued while the scan FSM is idle");

  read_valid_low_after_reset: assert property (@(posedge clk)
    rst |=> !io_rd_valid)
    else $error("io_rd_valid high in the cycle after reset");

  plain_read_latency: assert property (@(posedge clk) disable iff (rst)
    plain_read |=> io_rd_valid)
    else $error("plain read did not return io_rd_valid on the next cycle");

endmodule

bind accel_wrap accel_wrap_checker checker_i (
  .clk(clk), .rst(rst), .io_en(io_en), .io_wen(io_wen), .io_addr(io_addr),
  .io_rd_valid(io_rd_valid), .mem_rd_en(mem_rd_en), .busy(busy)
);

// ==== sim/accel_wrap_tb.sv ====
`include "accel_cfg.svh"

module accel_wrap_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [11:0] A_CTRL  = 12'(accel_reg_pkg::CTRL);
  localparam logic [11:0] A_LEN   = 12'(accel_reg_pkg::LEN);
  localparam logic [11:0] A_ADDR  = 12'(accel_reg_pkg::ADDR);
  localparam logic [11:0] A_LANES = 12'(accel_reg_pkg::LANES);
  localparam logic [11:0] A_RULE  = 12'(accel_reg_pkg::RULE);
  localparam logic [11:0] A_REL   = 12'(accel_reg_pkg::RELEASE);
  localparam logic [11:0] A_SLOT  = 12'(accel_reg_pkg::SLOT);
  // aggregate status page
  localparam logic [11:0] A_DONE  = 12'h400 | 12'(accel_reg_pkg::STAT_DONE);
  localparam logic [11:0] A_BUSY  = 12'h400 | 12'(accel_reg_pkg::STAT_BUSY);
  localparam logic [11:0] A_DERR  = 12'h400 | 12'(accel_reg_pkg::STAT_DONE_ERR);

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic        io_en = 1'b0;
  logic        io_wen = 1'b0;
  logic [3:0]  io_strb = 4'h0;
  logic [11:0] io_addr = '0;
  logic [31:0] io_wr_data = '0;
  logic [31:0] io_rd_data;
  logic        io_rd_valid;
  logic        rule_wr_en = 1'b0;
  logic [7:0]  rule_wr_addr = '0;
  accel_scan_pkg::rule_entry_t rule_wr_data = '0;
  logic        mem_rd_en;
  accel_scan_pkg::pmem_addr_t mem_rd_addr;
  logic [31:0] mem_rd_data = '0;

  logic [31:0] seed = 32'hdf42_c6cd;
  logic [31:0] pmem [1024];
  int          mem_reads = 0;
  accel_scan_pkg::rule_entry_t rules_m [256];
  accel_scan_pkg::scan_result_t exp_q [$];

  // model results of the last scan
  accel_scan_pkg::lane_mask_t m_mask;
  accel_scan_pkg::lane_mask_t m_first_lanes;
  accel_scan_pkg::rule_id_t   m_rule;
  logic                       m_hit;

  always #4 clk = ~clk;

  accel_wrap dut_i (
    .clk(clk), .rst(rst), .io_en(io_en), .io_wen(io_wen), .io_strb(io_strb),
    .io_addr(io_addr), .io_wr_data(io_wr_data), .io_rd_data(io_rd_data),
    .io_rd_valid(io_rd_valid), .rule_wr_en(rule_wr_en), .rule_wr_addr(rule_wr_addr),
    .rule_wr_data(rule_wr_data), .mem_rd_en(mem_rd_en), .mem_rd_addr(mem_rd_addr),
    .mem_rd_data(mem_rd_data)
  );

  // packet memory, one cycle read latency, counts the reads
  always @(posedge clk) begin
    if (mem_rd_en) begin
      mem_rd_data <= pmem[mem_rd_addr];
      mem_reads++;
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic fail(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic timed_out(input string what);
    $display("timeout at %0t ns while waiting for %s", $time, what);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) fail($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_rule(input string what, input accel_scan_pkg::rule_id_t got,
                            input accel_scan_pkg::rule_id_t exp);
    if (got !== exp) fail($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_lanes(input string what, input accel_scan_pkg::lane_mask_t got,
                             input accel_scan_pkg::lane_mask_t exp);
    if (got !== exp) fail($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  task automatic check_result(input string what, input accel_scan_pkg::scan_result_t got,
                              input accel_scan_pkg::scan_result_t exp);
    if (got !== exp) fail($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic io_write(input logic [11:0] addr, input logic [31:0] data);
    @(posedge clk);
    io_en      <= 1'b1;
    io_wen     <= 1'b1;
    io_strb    <= 4'hf;
    io_addr    <= addr;
    io_wr_data <= data;
    @(posedge clk);
    io_en  <= 1'b0;
    io_wen <= 1'b0;
  endtask

  task automatic io_read(input logic [11:0] addr, output logic [31:0] data);
    @(posedge clk);
    io_en   <= 1'b1;
    io_wen  <= 1'b0;
    io_addr <= addr;
    @(posedge clk);
    io_en <= 1'b0;
    #1;
    if (!io_rd_valid) fail($sformatf("no io_rd_valid one cycle after read of %h", addr));
    data = io_rd_data;
  endtask

  // LANES read, io_addr stays put during the stall
  task automatic lanes_read(output logic [31:0] data);
    int cycles;
    @(posedge clk);
    io_en   <= 1'b1;
    io_wen  <= 1'b0;
    io_addr <= A_LANES;
    @(posedge clk);
    io_en <= 1'b0;
    cycles = 0;
    #1;
    while (!io_rd_valid) begin
      if (cycles > 200) timed_out("LANES read data");
      @(posedge clk);
      #1;
      cycles++;
    end
    data = io_rd_data;
  endtask

  task automatic wait_bit(input logic [11:0] addr, input logic value, input string what);
    logic [31:0] d;
    int          tries;
    tries = 0;
    io_read(addr, d);
    while (d[0] !== value) begin
      if (tries > 200) timed_out(what);
      io_read(addr, d);
      tries++;
    end
  endtask

  task automatic compute_model(input int addr, input int len);
    logic [31:0]                w;
    accel_scan_pkg::lane_mask_t lanes;
    m_mask = '0;
    m_hit  = 1'b0;
    m_rule = '0;
    m_first_lanes = '0;
    for (int k = 0; k < len; k++) begin
      w = pmem[(addr + k) % 1024];
      for (int i = 0; i < 4; i++) lanes[i] = rules_m[w[8*i +: 8]].valid;
      m_mask = m_mask | lanes;
      if (!m_hit && lanes != 0) begin
        m_hit = 1'b1;
        m_first_lanes = lanes;
        for (int i = 3; i >= 0; i--) begin
          if (lanes[i]) m_rule = rules_m[w[8*i +: 8]].id;
        end
      end
    end
  endtask

  task automatic start_scan(input int addr, input int len, input logic [7:0] slot);
    compute_model(addr, len);
    exp_q.push_back('{slot: slot, rule: m_rule, hit: m_hit});
    io_write(A_ADDR, 32'(addr));
    io_write(A_LEN, 32'(len));
    io_write(A_SLOT, {24'h0, slot});
    io_write(A_CTRL, 32'h1);
  endtask

  // checks the status and results of a finished scan, then frees its record
  task automatic finish_scan(input string what);
    logic [31:0] d;
    accel_scan_pkg::scan_result_t exp;
    wait_bit(A_DONE, 1'b1, {what, " done"});
    exp = exp_q.pop_front();
    io_read(A_CTRL, d);
    check_word({what, " status"}, d, 32'h0001_0100 | (32'(m_hit) << 9));
    io_read(A_LANES, d);
    check_lanes({what, " lanes"}, d[3:0], m_mask);
    io_read(A_RULE, d);
    check_rule({what, " rule"}, d[6:0], m_rule);
    io_read(A_SLOT, d);
    check_word({what, " slot"}, d, 32'h100 | 32'(exp.slot));
    check_result({what, " record"}, dut_i.result_head, exp);
    io_write(A_REL, 32'h0);
  endtask

  initial begin
    logic [31:0] d;
    int          a;
    int          n;
    int          reads_before;
    for (int i = 0; i < 1024; i++) pmem[i] = next_rand();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int b = 0; b < 256; b++) begin
      d = next_rand();
      rules_m[b] = '{valid: (d[3:0] == 4'h0), id: d[14:8]};
      @(posedge clk);
      rule_wr_en   <= 1'b1;
      rule_wr_addr <= 8'(b);
      rule_wr_data <= rules_m[b];
    end
    @(posedge clk);
    rule_wr_en <= 1'b0;

    // descriptor read-back
    io_write(A_LEN, 32'h0000_0a5c);
    io_read(A_LEN, d);
    check_word("LEN read-back", d, 32'h0000_0a5c);
    io_write(A_ADDR, 32'h0000_02b7);
    io_read(A_ADDR, d);
    check_word("ADDR read-back", d, 32'h0000_02b7);
    io_write(A_SLOT, 32'h0000_0093);
    io_read(A_SLOT, d);
    check_word("SLOT read-back", d, 32'h0000_0093);

    // random scans
    for (int s = 0; s < 20; s++) begin
      start_scan(next_rand() % 1024, next_rand() % 13, 8'(next_rand()));
      finish_scan($sformatf("scan %0d", s));
    end

    // stalling LANES read right after start
    for (int s = 0; s < 6; s++) begin
      start_scan(next_rand() % 1024, 1 + next_rand() % 12, 8'(next_rand()));
      lanes_read(d);
      check_lanes("early lanes outside full mask", d[3:0] & ~m_mask, '0);
      check_lanes("early lanes of first hit", d[3:0] & m_first_lanes, m_first_lanes);
      finish_scan($sformatf("stalled scan %0d", s));
    end

    // result queue fills at four records
    for (int s = 0; s < 4; s++) begin
      start_scan(next_rand() % 1024, next_rand() % 13, 8'(s + 8'h40));
      wait_bit(A_DONE, 1'b1, "queued scan done");
    end
    start_scan(next_rand() % 1024, 2, 8'h44);
    for (int i = 0; i < 6; i++) begin
      io_read(A_BUSY, d);
      check_word("busy with full result queue", d, 32'h1);
    end
    for (int s = 0; s < 5; s++) begin
      io_read(A_SLOT, d);
      check_word("queued slot", d, 32'h100 | 32'(exp_q[0].slot));
      check_result("queued record", dut_i.result_head, exp_q[0]);
      void'(exp_q.pop_front());
      io_write(A_REL, 32'h0);
      if (s == 0) wait_bit(A_DONE, 1'b1, "fifth scan done");
    end

    // second start during a long scan
    a = next_rand() % 1024;
    start_scan(a, 12, 8'h71);
    io_write(A_CTRL, 32'h1);
    wait_bit(A_DONE, 1'b1, "long scan done");
    io_read(A_DERR, d);
    check_word("done_err after start while busy", d, 32'h1);
    finish_scan("long scan");

    // stop ends a long scan before all of its reads
    reads_before = mem_reads;
    start_scan(next_rand() % 1024, 12, 8'h72);
    void'(exp_q.pop_back());
    io_write(A_CTRL, 32'h10);
    wait_bit(A_BUSY, 1'b0, "idle after stop");
    if (mem_reads - reads_before >= 12) begin
      fail($sformatf("scan still issued %0d of 12 reads after stop",
                     mem_reads - reads_before));
    end
    io_read(A_DONE, d);
    check_word("done after stop", d, 32'h1);
    io_write(A_REL, 32'h0);

    // zero-length scan
    n = 0;
    start_scan(next_rand() % 1024, n, 8'h73);
    finish_scan("zero length scan");

    if (exp_q.size() != 0) begin
      fail("expected result records left over");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

// ==== accel_wrap.f ====
+incdir+common
common/accel_reg_pkg.sv
common/accel_scan_pkg.sv
design/sync_fifo.sv
design/accel_regs.sv
scan/scan_ctrl_fsm.sv
scan/scan_word_counter.sv
scan/scan_byte_matcher.sv
design/accel_wrap.sv
sim/accel_wrap_checker.sv
sim/accel_wrap_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= accel_wrap_tb
FILELIST  ?= accel_wrap.f

SRCS := $(shell grep -v '^+' $(FILELIST)) common/accel_cfg.svh
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q '^NO ERRORS$$'

clean:
	rm -rf obj_dir
